// File: files.f
rtl/board_pkg.sv
rtl/board_rstgen.sv
rtl/board_cfg_regs.sv
rtl/rtc_divider.sv
rtl/fan_pwm.sv
rtl/board_shell_top.sv
tb/tb_board_shell.sv

// File: Makefile
# Verilator build and run for the board shell testbench
VERILATOR ?= verilator
TOP       ?= tb_board_shell
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Everything OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean
.DEFAULT_GOAL := help

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_board_shell.sv
//////////////////////////////////////////////////
// Board shell testbench
// Random Wishbone traffic and pin stimulus with a
// register shadow, PWM duty, RTC and SD pin checks
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_board_shell;

  import board_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int ACK_TIMEOUT    = 16;
  localparam int WB_CYCLES      = 8;
  localparam int REG_OPS        = 200;
  localparam int FAN_CASES      = 8;
  localparam int FAN_PERIOD     = 16 * FAN_PRESCALE;
  localparam int RTC_CASES      = 6;
  localparam int RTC_EDGE_LIMIT = 600;
  localparam int SD_ROUNDS      = 8;
  localparam int SD_VECTORS     = 16;
  localparam int STATUS_CASES   = 20;

  // Budget of every test added up, plus slack
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 10 * WB_CYCLES
    + REG_OPS * (2 * WB_CYCLES + 4)
    + FAN_CASES * (2 * WB_CYCLES + 10 * FAN_PERIOD)
    + RTC_CASES * (WB_CYCLES + 3 * RTC_EDGE_LIMIT)
    + SD_ROUNDS * (WB_CYCLES + 2 + SD_VECTORS)
    + STATUS_CASES * (WB_CYCLES + 2) + 1000;

  logic       soc_clk;
  logic       rst_n;
  logic       test_mode;
  logic [1:0] boot_pins;
  logic [3:0] fan_sw;
  logic       sd_cd;
  logic       sd_dat0;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;
  spi_pins_t  spih;
  logic [3:0] spih_sd;
  sd_pins_t   sd_pins;
  logic [1:0] boot_mode;
  logic [1:0] boot_safety;
  logic       fan_pwm;
  logic       rtc_clk;

  logic [31:0] rng_state;
  int          err_count;
  int          chk_count;
  int          tests_run;
  int          test_err0;
  int          test_chk0;

  // Register shadow
  logic       sh_ctrl;
  logic [3:0] sh_boot;
  logic [3:0] sh_fan_lvl;
  logic       sh_fan_ovr;
  logic [7:0] sh_rtc;

  board_shell_top DUT (
    .soc_clk       ( soc_clk     ),
    .rst_n         ( rst_n       ),
    .test_mode_i   ( test_mode   ),
    .boot_mode_i   ( boot_pins   ),
    .fan_sw_i      ( fan_sw      ),
    .wb_i          ( wb_req      ),
    .wb_o          ( wb_rsp      ),
    .spih_i        ( spih        ),
    .spih_sd_o     ( spih_sd     ),
    .sd_cd_i       ( sd_cd       ),
    .sd_dat0_i     ( sd_dat0     ),
    .sd_o          ( sd_pins     ),
    .boot_mode_o   ( boot_mode   ),
    .boot_safety_o ( boot_safety ),
    .fan_pwm_o     ( fan_pwm     ),
    .rtc_clk_o     ( rtc_clk     )
  );

  initial begin
    soc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) soc_clk = ~soc_clk;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_count++;
    if (got !== exp) begin
      err_count++;
      $display("Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic begin_test();
    test_err0 = err_count;
    test_chk0 = chk_count;
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    $display("Test %0d %s: %0d checks, %0d errors", num, name,
             chk_count - test_chk0, err_count - test_err0);
  endtask

  // Read value the register map should return
  function automatic logic [31:0] expected_read(input logic [3:0] adr);
    logic [31:0] v;
    v = '0;
    case (adr)
      REG_CTRL: v[0] = sh_ctrl;
      REG_BOOT: v[3:0] = sh_boot;
      REG_FAN: begin
        v[3:0] = sh_fan_lvl;
        v[8]   = sh_fan_ovr;
      end
      REG_RTC: v[7:0] = sh_rtc;
      REG_STATUS: begin
        v[1:0] = boot_pins;
        v[7:4] = fan_sw;
        v[8]   = sd_cd;
        v[9]   = test_mode;
      end
      REG_ID: v = BOARD_ID;
      default: v = '0;
    endcase
    return v;
  endfunction

  task automatic model_write(input logic [3:0] adr, input logic [31:0] dat);
    case (adr)
      REG_CTRL: sh_ctrl = dat[0];
      REG_BOOT: sh_boot = dat[3:0];
      REG_FAN: begin
        sh_fan_lvl = dat[3:0];
        sh_fan_ovr = dat[8];
      end
      REG_RTC: sh_rtc = (dat[7:0] == 8'd0) ? 8'd1 : dat[7:0];
      default: ;
    endcase
  endtask

  // One classic cycle, request held until ack, dropped after the ack edge
  task automatic wb_transfer(input logic we, input logic [3:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
    int   waited;
    logic acked;
    waited = 0;
    acked  = 1'b0;
    rdat   = '0;
    @(posedge soc_clk);
    #2;
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = we;
    wb_req.adr = adr;
    wb_req.dat = wdat;
    while (!acked && waited < ACK_TIMEOUT) begin
      @(posedge soc_clk);
      #1;
      waited++;
      if (wb_rsp.ack) begin
        acked = 1'b1;
        rdat  = wb_rsp.dat;
      end
    end
    if (!acked) begin
      err_count++;
      $display("Wishbone slave gave no ack to an access at address %0d", adr);
    end
    @(posedge soc_clk);
    #2;
    wb_req = '0;
  endtask

  task automatic reg_write(input logic [3:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    wb_transfer(1'b1, adr, dat, unused);
    model_write(adr, dat);
  endtask

  task automatic reg_read_check(input logic [3:0] adr);
    logic [31:0] rd;
    wb_transfer(1'b0, adr, 32'd0, rd);
    // RTC level in STATUS runs freely
    if (adr == REG_STATUS) begin
      rd = rd & ~32'h0000_0400;
    end
    check($sformatf("read of register %0d", adr), rd, expected_read(adr));
  endtask

  task automatic check_boot_outputs();
    @(posedge soc_clk);
    #1;
    check("boot_mode_o", 32'(boot_mode), 32'(boot_pins | sh_boot[1:0]));
    check("boot_safety_o", 32'(boot_safety), 32'(sh_boot[3:2]));
  endtask

  // Cycles until rtc_clk_o next changes
  task automatic wait_rtc_edge(output int cycles);
    logic prev;
    logic changed;
    prev    = rtc_clk;
    changed = 1'b0;
    cycles  = 0;
    while (!changed && cycles < RTC_EDGE_LIMIT) begin
      @(posedge soc_clk);
      #1;
      cycles++;
      if (rtc_clk != prev) begin
        changed = 1'b1;
      end
    end
    if (!changed) begin
      err_count++;
      $display("rtc_clk_o stopped toggling for %0d cycles", RTC_EDGE_LIMIT);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic run_reset_test();
    begin_test();
    repeat (RESET_CYCLES / 2) @(posedge soc_clk);
    #1;
    check("ack in reset", 32'(wb_rsp.ack), 32'd0);
    check("fan_pwm_o in reset", 32'(fan_pwm), 32'd0);
    check("rtc_clk_o in reset", 32'(rtc_clk), 32'd0);
    check("sd_o.reset in reset", 32'(sd_pins.reset), 32'd0);
    repeat (RESET_CYCLES / 2) @(posedge soc_clk);
    #2;
    rst_n = 1'b1;
    repeat (RST_SYNC_STAGES + 2) @(posedge soc_clk);
    for (int a = 0; a < 8; a++) begin
      reg_read_check(4'(a));
    end
    check_boot_outputs();
    end_test(1, "reset defaults");
  endtask

  task automatic run_register_test();
    logic [31:0] r;
    logic [3:0]  adr;
    begin_test();
    for (int i = 0; i < REG_OPS; i++) begin
      r = next_random();
      @(posedge soc_clk);
      #2;
      boot_pins = r[5:4];
      fan_sw    = r[9:6];
      adr       = r[3:0];
      if (i % 50 == 0) begin
        // Zero half period must read back as one
        reg_write(REG_RTC, next_random() & 32'hFFFF_FF00);
        reg_read_check(REG_RTC);
      end else if (r[10]) begin
        reg_write(adr, next_random());
      end else begin
        reg_read_check(adr);
      end
      check_boot_outputs();
    end
    end_test(2, "register traffic");
  endtask

  task automatic run_fan_test();
    logic [31:0] r;
    logic [3:0]  level;
    int          highs;
    int          exp_high;
    begin_test();
    for (int c = 0; c < FAN_CASES; c++) begin
      r = next_random();
      level = (c == 0) ? 4'hF : (c == 1) ? 4'h0 : r[3:0];
      @(posedge soc_clk);
      #2;
      if (r[4]) begin
        fan_sw = r[11:8];
        reg_write(REG_FAN, 32'h0000_0100 | 32'(level));
      end else begin
        fan_sw = level;
        reg_write(REG_FAN, 32'(r[15:12]));
      end
      repeat (2 * FAN_PERIOD) @(posedge soc_clk);
      highs = 0;
      repeat (8 * FAN_PERIOD) begin
        @(posedge soc_clk);
        #1;
        if (fan_pwm) begin
          highs++;
        end
      end
      exp_high = int'(level) * int'(FAN_PRESCALE) * 8;
      check($sformatf("fan high cycles at level %0d", level), 32'(highs), 32'(exp_high));
    end
    end_test(3, "fan duty");
  endtask

  task automatic run_rtc_test();
    logic [31:0] r;
    logic [7:0]  half;
    int          n;
    begin_test();
    for (int c = 0; c < RTC_CASES; c++) begin
      r = next_random();
      half = 8'd1 + {2'b00, r[5:0]};
      reg_write(REG_RTC, 32'(half));
      wait_rtc_edge(n);
      wait_rtc_edge(n);
      wait_rtc_edge(n);
      check($sformatf("RTC half period %0d", half), 32'(n), 32'(half));
    end
    end_test(4, "RTC period");
  endtask

  task automatic run_sd_test();
    logic [31:0] r;
    sd_pins_t    exp_sd;
    logic [3:0]  exp_spi;
    begin_test();
    for (int k = 0; k < SD_ROUNDS; k++) begin
      reg_write(REG_CTRL, 32'(next_random() & 32'd1));
      @(posedge soc_clk);
      for (int v = 0; v < SD_VECTORS; v++) begin
        r = next_random();
        @(posedge soc_clk);
        #2;
        spih    = spi_pins_t'(r[13:0]);
        sd_dat0 = r[14];
        #5;
        exp_sd.sclk  = spih.sck_en ? spih.sck : 1'b1;
        exp_sd.cmd   = spih.sd_en[0] ? spih.sd[0] : 1'b1;
        exp_sd.dat3  = spih.csb_en[0] ? spih.csb[0] : 1'b1;
        exp_sd.dat21 = 2'b11;
        exp_sd.reset = ~sh_ctrl;
        // Card MISO returns on host line 1 only
        exp_spi    = 4'b0000;
        exp_spi[1] = sd_dat0;
        check("SD pins", {26'b0, sd_pins}, {26'b0, exp_sd});
        check("spih_sd_o", 32'(spih_sd), 32'(exp_spi));
      end
    end
    end_test(5, "SD mapping");
  endtask

  task automatic run_status_test();
    logic [31:0] r;
    begin_test();
    for (int c = 0; c < STATUS_CASES; c++) begin
      r = next_random();
      @(posedge soc_clk);
      #2;
      boot_pins = r[1:0];
      fan_sw    = r[7:4];
      sd_cd     = r[8];
      test_mode = r[9];
      reg_read_check(REG_STATUS);
    end
    @(posedge soc_clk);
    #2;
    test_mode = 1'b0;
    end_test(6, "status");
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    rst_n      = 1'b0;
    test_mode  = 1'b0;
    boot_pins  = '0;
    fan_sw     = '0;
    sd_cd      = 1'b0;
    sd_dat0    = 1'b0;
    wb_req     = '0;
    spih       = '0;
    rng_state  = 32'h4294;
    err_count  = 0;
    chk_count  = 0;
    tests_run  = 0;
    sh_ctrl    = 1'b1;
    sh_boot    = '0;
    sh_fan_lvl = '0;
    sh_fan_ovr = 1'b0;
    sh_rtc     = RTC_HALF_DEFAULT;

    run_reset_test();
    run_register_test();
    run_fan_test();
    run_rtc_test();
    run_sd_test();
    run_status_test();

    $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, chk_count, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge soc_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Something failed");
    $finish;
  end

endmodule

// File: rtl/board_shell_top.sv
//////////////////////////////////////////////////
// Board shell top
// Reset, RTC, fan and boot control around the SoC,
// plus the SPI to SD card pin mapping
//////////////////////////////////////////////////

`timescale 1ns/10ps

module board_shell_top (
  input  logic                          soc_clk,
  input  logic                          rst_n,
  input  logic                          test_mode_i,
  input  logic [board_pkg::BOOT_MODE_W-1:0] boot_mode_i,
  input  logic [board_pkg::FAN_LEVEL_W-1:0] fan_sw_i,
  input  board_pkg::wb_req_t            wb_i,
  output board_pkg::wb_rsp_t            wb_o,
  input  board_pkg::spi_pins_t          spih_i,
  output logic [3:0]                    spih_sd_o,
  input  logic                          sd_cd_i,
  input  logic                          sd_dat0_i,
  output board_pkg::sd_pins_t           sd_o,
  output logic [board_pkg::BOOT_MODE_W-1:0] boot_mode_o,
  output logic [board_pkg::BOOT_MODE_W-1:0] boot_safety_o,
  output logic                          fan_pwm_o,
  output logic                          rtc_clk_o
);

  import board_pkg::*;

  logic                   rst_sync_n;
  logic [FAN_LEVEL_W-1:0] fan_level;
  logic [RTC_DIV_W-1:0]   rtc_half;
  logic                   sd_power_en;

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  board_rstgen u_rstgen (
    .soc_clk      ( soc_clk     ),
    .rst_n        ( rst_n       ),
    .test_mode_i  ( test_mode_i ),
    .rst_sync_n_o ( rst_sync_n  )
  );

  //////////////////////////////////////////////////
  // Configuration and timers
  //////////////////////////////////////////////////

  board_cfg_regs u_cfg_regs (
    .soc_clk       ( soc_clk       ),
    .rst_n         ( rst_sync_n    ),
    .wb_i          ( wb_i          ),
    .wb_o          ( wb_o          ),
    .boot_mode_i   ( boot_mode_i   ),
    .fan_sw_i      ( fan_sw_i      ),
    .sd_cd_i       ( sd_cd_i       ),
    .test_mode_i   ( test_mode_i   ),
    .rtc_clk_i     ( rtc_clk_o     ),
    .boot_mode_o   ( boot_mode_o   ),
    .boot_safety_o ( boot_safety_o ),
    .fan_level_o   ( fan_level     ),
    .rtc_half_o    ( rtc_half      ),
    .sd_power_en_o ( sd_power_en   )
  );

  rtc_divider u_rtc_divider (
    .soc_clk       ( soc_clk    ),
    .rst_n         ( rst_sync_n ),
    .half_period_i ( rtc_half   ),
    .rtc_clk_o     ( rtc_clk_o  )
  );

  fan_pwm u_fan_pwm (
    .soc_clk   ( soc_clk    ),
    .rst_n     ( rst_sync_n ),
    .level_i   ( fan_level  ),
    .fan_pwm_o ( fan_pwm_o  )
  );

  //////////////////////////////////////////////////
  // SD card in SPI mode
  //////////////////////////////////////////////////

  // Idle lines float high when the host releases them
  assign sd_o.sclk  = spih_i.sck_en    ? spih_i.sck    : 1'b1;
  assign sd_o.dat3  = spih_i.csb_en[0] ? spih_i.csb[0] : 1'b1;
  assign sd_o.cmd   = spih_i.sd_en[0]  ? spih_i.sd[0]  : 1'b1;
  // DAT1 and DAT2 unused in SPI mode
  assign sd_o.dat21 = 2'b11;
  // Low reset powers the card
  assign sd_o.reset = ~sd_power_en;

  // DAT0 is the card's MISO, on host data line 1
  assign spih_sd_o = {2'b00, sd_dat0_i, 1'b0};

endmodule

// File: rtl/fan_pwm.sv
//////////////////////////////////////////////////
// Fan PWM
// Prescaled 16-step PWM, level sampled once per
// period so the duty never jumps mid period
//////////////////////////////////////////////////

`timescale 1ns/10ps

module fan_pwm (
  input  logic                          soc_clk,
  input  logic                          rst_n,
  input  logic [board_pkg::FAN_LEVEL_W-1:0] level_i,
  output logic                          fan_pwm_o
);

  import board_pkg::*;

  localparam int unsigned PRE_W = $clog2(FAN_PRESCALE);

  logic [PRE_W-1:0]       pre_q;
  logic [FAN_LEVEL_W-1:0] step_q;
  logic [FAN_LEVEL_W-1:0] step_d;
  logic [FAN_LEVEL_W-1:0] level_q;
  logic [FAN_LEVEL_W-1:0] level_d;
  logic                   tick;
  logic                   pwm_q;

  assign tick = (pre_q == PRE_W'(FAN_PRESCALE - 1));

  // Next step and level, the level is sampled as the step wraps
  always_comb begin
    step_d  = step_q;
    level_d = level_q;
    if (tick) begin
      step_d = step_q + FAN_LEVEL_W'(1);
      if (step_q == '1) begin
        level_d = level_i;
      end
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q   <= '0;
      step_q  <= '0;
      level_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      pre_q   <= tick ? '0 : pre_q + PRE_W'(1);
      step_q  <= step_d;
      level_q <= level_d;
      // Registered compare keeps the pin free of glitches
      pwm_q   <= (step_d < level_d);
    end
  end

  assign fan_pwm_o = pwm_q;

  a_off_at_zero : assert property (
    @(posedge soc_clk) disable iff (!rst_n) (level_q == '0) |-> !fan_pwm_o)
    else $error("fan PWM high with a zero level");

endmodule

// File: rtl/rtc_divider.sv
//////////////////////////////////////////////////
// RTC divider
// Toggles the real-time clock every half period of
// soc_clk cycles
//////////////////////////////////////////////////

`timescale 1ns/10ps

module rtc_divider (
  input  logic                        soc_clk,
  input  logic                        rst_n,
  input  logic [board_pkg::RTC_DIV_W-1:0] half_period_i,
  output logic                        rtc_clk_o
);

  import board_pkg::*;

  logic [RTC_DIV_W-1:0] cnt_q;
  // Half period in use for the current phase
  logic [RTC_DIV_W-1:0] half_q;
  logic                 rtc_q;
  logic                 toggle;

  assign toggle = (cnt_q == half_q - RTC_DIV_W'(1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      half_q <= RTC_HALF_DEFAULT;
      rtc_q  <= 1'b0;
    end else if (toggle) begin
      // New setting only at a toggle, so no phase is cut short
      cnt_q  <= '0;
      half_q <= half_period_i;
      rtc_q  <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + RTC_DIV_W'(1);
    end
  end

  assign rtc_clk_o = rtc_q;

  a_cnt_in_range : assert property (
    @(posedge soc_clk) disable iff (!rst_n) cnt_q < half_q)
    else $error("RTC counter beyond the latched half period");

endmodule

// File: rtl/board_cfg_regs.sv
//////////////////////////////////////////////////
// Board configuration registers
// Wishbone classic slave that steers boot mode,
// fan level, RTC half period and SD card power
//////////////////////////////////////////////////

`timescale 1ns/10ps

module board_cfg_regs (
  input  logic                          soc_clk,
  input  logic                          rst_n,
  input  board_pkg::wb_req_t            wb_i,
  output board_pkg::wb_rsp_t            wb_o,
  input  logic [board_pkg::BOOT_MODE_W-1:0] boot_mode_i,
  input  logic [board_pkg::FAN_LEVEL_W-1:0] fan_sw_i,
  input  logic                          sd_cd_i,
  input  logic                          test_mode_i,
  input  logic                          rtc_clk_i,
  output logic [board_pkg::BOOT_MODE_W-1:0] boot_mode_o,
  output logic [board_pkg::BOOT_MODE_W-1:0] boot_safety_o,
  output logic [board_pkg::FAN_LEVEL_W-1:0] fan_level_o,
  output logic [board_pkg::RTC_DIV_W-1:0]   rtc_half_o,
  output logic                          sd_power_en_o
);

  import board_pkg::*;

  wb_state_e state_q;
  logic      wr_en;

  logic [WB_DAT_W-1:0]    rdata;

  // Register fields
  logic                   sd_power_q;
  logic [BOOT_MODE_W-1:0] boot_host_q;
  logic [BOOT_MODE_W-1:0] boot_safe_q;
  logic [FAN_LEVEL_W-1:0] fan_level_q;
  logic                   fan_ovr_q;
  logic [RTC_DIV_W-1:0]   rtc_half_q;

  //////////////////////////////////////////////////
  // Slave FSM
  //////////////////////////////////////////////////

  // One ack per request, then back to idle
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WB_IDLE;
    end else begin
      case (state_q)
        WB_IDLE: begin
          if (wb_i.cyc && wb_i.stb) begin
            state_q <= WB_ACK;
          end
        end
        default: state_q <= WB_IDLE;
      endcase
    end
  end

  assign wb_o.ack = (state_q == WB_ACK);
  assign wb_o.dat = wb_o.ack ? rdata : '0;

  // Commit on the ack edge
  assign wr_en = wb_o.ack && wb_i.cyc && wb_i.stb && wb_i.we;

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sd_power_q  <= 1'b1;
      boot_host_q <= '0;
      boot_safe_q <= '0;
      fan_level_q <= '0;
      fan_ovr_q   <= 1'b0;
      rtc_half_q  <= RTC_HALF_DEFAULT;
    end else if (wr_en) begin
      case (cfg_reg_e'(wb_i.adr))
        REG_CTRL: sd_power_q <= wb_i.dat[0];
        REG_BOOT: begin
          boot_host_q <= wb_i.dat[1:0];
          boot_safe_q <= wb_i.dat[3:2];
        end
        REG_FAN: begin
          fan_level_q <= wb_i.dat[3:0];
          fan_ovr_q   <= wb_i.dat[8];
        end
        REG_RTC: begin
          // A zero half period would stall the divider
          if (wb_i.dat[7:0] == '0) begin
            rtc_half_q <= RTC_DIV_W'(1);
          end else begin
            rtc_half_q <= wb_i.dat[7:0];
          end
        end
        default: ;
      endcase
    end
  end

  // Read mux, unmapped words return zero
  always_comb begin
    rdata = '0;
    case (cfg_reg_e'(wb_i.adr))
      REG_CTRL: rdata[0] = sd_power_q;
      REG_BOOT: rdata[3:0] = {boot_safe_q, boot_host_q};
      REG_FAN: begin
        rdata[3:0] = fan_level_q;
        rdata[8]   = fan_ovr_q;
      end
      REG_RTC: rdata[7:0] = rtc_half_q;
      REG_STATUS: begin
        rdata[1:0] = boot_mode_i;
        rdata[7:4] = fan_sw_i;
        rdata[8]   = sd_cd_i;
        rdata[9]   = test_mode_i;
        rdata[10]  = rtc_clk_i;
      end
      REG_ID: rdata = BOARD_ID;
      default: rdata = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////

  // Boot and power pins land one edge after the write
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_mode_o   <= '0;
      boot_safety_o <= '0;
      sd_power_en_o <= 1'b1;
    end else begin
      boot_mode_o   <= boot_mode_i | boot_host_q;
      boot_safety_o <= boot_safe_q;
      sd_power_en_o <= sd_power_q;
    end
  end

  // Switches rule unless software takes over
  assign fan_level_o = fan_ovr_q ? fan_level_q : fan_sw_i;
  assign rtc_half_o  = rtc_half_q;

  a_ack_single : assert property (
    @(posedge soc_clk) disable iff (!rst_n) wb_o.ack |=> !wb_o.ack)
    else $error("ack held high for two cycles");

  a_rtc_half_nonzero : assert property (
    @(posedge soc_clk) disable iff (!rst_n) rtc_half_o != '0)
    else $error("RTC half period is zero");

endmodule

// File: rtl/board_rstgen.sv
//////////////////////////////////////////////////
// Board reset generator
// Asserts asynchronously and releases in sync with
// soc_clk; test mode passes the pin straight through
//////////////////////////////////////////////////

`timescale 1ns/10ps

module board_rstgen (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic rst_sync_n_o
);

  import board_pkg::*;

  // Release chain, fills with ones after the pin rises
  logic [RST_SYNC_STAGES-1:0] sync_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  // Scan and test runs need the reset under direct pin control
  assign rst_sync_n_o = test_mode_i ? rst_n : sync_q[RST_SYNC_STAGES-1];

endmodule

// File: rtl/board_pkg.sv
//////////////////////////////////////////////////
// Board shell package
// Field sizes, Wishbone and pin bundles, and the
// register map of the configuration block
//////////////////////////////////////////////////

package board_pkg;

  // Field widths
  localparam int unsigned BOOT_MODE_W = 2;
  localparam int unsigned FAN_LEVEL_W = 4;
  localparam int unsigned RTC_DIV_W   = 8;

  // soc_clk cycles per PWM step
  localparam int unsigned FAN_PRESCALE = 4;

  // RTC toggles every ten cycles out of reset
  localparam logic [RTC_DIV_W-1:0] RTC_HALF_DEFAULT = 8'd10;

  // Wishbone sizes, word addressed
  localparam int unsigned WB_ADR_W = 4;
  localparam int unsigned WB_DAT_W = 32;

  localparam int unsigned RST_SYNC_STAGES = 2;

  localparam logic [WB_DAT_W-1:0] BOARD_ID = 32'hB0A2_5E11;

  //////////////////////////////////////////////////
  // Bus and pin bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // Outputs of the SPI host, enables are active high
  typedef struct packed {
    logic       sck;
    logic       sck_en;
    logic [1:0] csb;
    logic [1:0] csb_en;
    logic [3:0] sd;
    logic [3:0] sd_en;
  } spi_pins_t;

  // SD card pins in SPI mode
  typedef struct packed {
    logic       sclk;
    logic       cmd;
    logic       dat3;
    logic [1:0] dat21;
    logic       reset;
  } sd_pins_t;

  //////////////////////////////////////////////////
  // Register map and slave states
  //////////////////////////////////////////////////

  typedef enum logic [WB_ADR_W-1:0] {
    REG_CTRL   = 4'd0,
    REG_BOOT   = 4'd1,
    REG_FAN    = 4'd2,
    REG_RTC    = 4'd3,
    REG_STATUS = 4'd4,
    REG_ID     = 4'd5
  } cfg_reg_e;

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage
